//--- logic/bus_map_pkg.sv
package bus_map_pkg;

    // Bus widths
    localparam int BUS_ADDR_BITS = 64;
    localparam int BUS_DATA_BITS = 64;
    localparam int MEM_WORD_BITS = 32;
    localparam int IRQ_BITS      = 4;

    typedef logic [BUS_ADDR_BITS-1:0] bus_addr_t;
    typedef logic [BUS_DATA_BITS-1:0] bus_data_t;
    typedef logic [MEM_WORD_BITS-1:0] mem_word_t;
    typedef logic [IRQ_BITS-1:0]      irq_vec_t;

    // Shared word memory, ROM in the lower half
    localparam bus_addr_t ROM_BASE = 64'h0000_0000_0000_0000;
    localparam bus_addr_t ROM_SIZE = 64'h0000_0000_0000_0100;
    localparam bus_addr_t RAM_BASE = 64'h0000_0000_0000_0100;
    localparam bus_addr_t RAM_SIZE = 64'h0000_0000_0000_0100;

    localparam int MEM_WORDS      = 128;
    localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);

    // Single-address peripherals
    localparam bus_addr_t ART_BASE = 64'h0000_0000_0000_1000;
    localparam bus_addr_t KEY_BASE = 64'h0000_0000_0000_1008;

    // Vector raised by a key press
    localparam irq_vec_t KEY_IRQ_VECTOR = 4'd1;

endpackage

//--- logic/kbd_pkg.sv
package kbd_pkg;

    typedef logic [7:0] ascii_t;
    typedef logic [7:0] scan_t;

    // Start, eight data bits, odd parity, stop
    localparam int FRAME_BITS = 11;

    // Set-2 prefix codes
    localparam scan_t BREAK_CODE = 8'hF0;
    localparam scan_t EXT_CODE   = 8'hE0;

    // CLOCK_50 cycles without a falling PS/2 clock before a partial frame is dropped
    localparam int IDLE_TIMEOUT = 2000;

endpackage

//--- logic/ps2_frame_timer.sv
`timescale 1ns/1ps

module ps2_frame_timer (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       bit_strobe,
    input  logic       frame_active,
    output logic [3:0] bit_index,
    output logic       idle_expired
);
    import kbd_pkg::*;

    localparam int IDLE_W = $clog2(IDLE_TIMEOUT);

    logic [IDLE_W-1:0] idle_count;

    // Idle counter restarts on every received bit
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            idle_count   <= '0;
            idle_expired <= 1'b0;
        end else begin
            idle_expired <= 1'b0;
            if (!frame_active || bit_strobe) begin
                idle_count <= '0;
            end else if (idle_count == IDLE_W'(IDLE_TIMEOUT - 1)) begin
                idle_count   <= '0;
                idle_expired <= 1'b1;
            end else begin
                idle_count <= idle_count + 1'b1;
            end
        end
    end

    // Timeout wins, then a new bit, then end of frame
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_index <= '0;
        end else if (idle_expired) begin
            bit_index <= '0;
        end else if (bit_strobe) begin
            bit_index <= bit_index + 1'b1;
        end else if (!frame_active) begin
            bit_index <= '0;
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bit_index <= FRAME_BITS);

endmodule

//--- logic/ps2_frame_fsm.sv
`timescale 1ns/1ps

module ps2_frame_fsm (
    input  logic           CLOCK_50,
    input  logic           KEY0,
    input  logic           ps2_clk,
    input  logic           ps2_dat,
    output kbd_pkg::scan_t scan_code,
    output logic           key_make,
    output logic           key_break
);
    import kbd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_receive,
        st_check
    } state_t;

    state_t                  state;
    logic                    ps2_clk_meta;
    logic                    ps2_clk_sync;
    logic                    ps2_clk_prev;
    logic                    ps2_dat_meta;
    logic                    ps2_dat_sync;
    logic                    ps2_fall;
    logic                    bit_strobe;
    logic                    frame_active;
    logic [3:0]              bit_index;
    logic                    idle_expired;
    logic [FRAME_BITS-1:0]   frame;
    logic                    frame_ok;
    logic                    break_pending;
    scan_t                   code;

    // Two-flop synchronizers, lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ps2_clk_meta <= 1'b1;
            ps2_clk_sync <= 1'b1;
            ps2_clk_prev <= 1'b1;
            ps2_dat_meta <= 1'b1;
            ps2_dat_sync <= 1'b1;
        end else begin
            ps2_clk_meta <= ps2_clk;
            ps2_clk_sync <= ps2_clk_meta;
            ps2_clk_prev <= ps2_clk_sync;
            ps2_dat_meta <= ps2_dat;
            ps2_dat_sync <= ps2_dat_meta;
        end
    end

    assign ps2_fall     = ps2_clk_prev && !ps2_clk_sync;
    assign bit_strobe   = ps2_fall && (state == st_idle || state == st_receive);
    assign frame_active = (state != st_idle);

    ps2_frame_timer timer_i (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bit_strobe   (bit_strobe),
        .frame_active (frame_active),
        .bit_index    (bit_index),
        .idle_expired (idle_expired)
    );

    // Frame bits arrive LSB first, start bit ends up in bit 0
    assign code     = frame[8:1];
    assign frame_ok = !frame[0] && frame[FRAME_BITS-1] && (^frame[9:1]);

    always_ff @(posedge CLOCK_50) begin
        if (bit_strobe) begin
            frame <= {ps2_dat_sync, frame[FRAME_BITS-1:1]};
        end
        if (state == st_check) begin
            scan_code <= code;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state         <= st_idle;
            break_pending <= 1'b0;
            key_make      <= 1'b0;
            key_break     <= 1'b0;
        end else begin
            key_make  <= 1'b0;
            key_break <= 1'b0;
            case (state)
                st_idle: begin
                    if (ps2_fall) begin
                        state <= st_receive;
                    end
                end
                st_receive: begin
                    if (idle_expired) begin
                        state <= st_idle;
                    end else if (ps2_fall && bit_index == 4'(FRAME_BITS - 1)) begin
                        state <= st_check;
                    end
                end
                st_check: begin
                    state <= st_idle;
                    if (frame_ok) begin
                        if (code == BREAK_CODE) begin
                            break_pending <= 1'b1;
                        end else if (code != EXT_CODE) begin
                            // Key after F0 is a release
                            key_make      <= !break_pending;
                            key_break     <= break_pending;
                            break_pending <= 1'b0;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) !(key_make && key_break));

endmodule

//--- logic/scan_ascii_table.sv
`timescale 1ns/1ps

module scan_ascii_table (
    input  logic            CLOCK_50,
    input  logic            KEY0,
    input  kbd_pkg::scan_t  scan_code,
    input  logic            key_make,
    output kbd_pkg::ascii_t ascii,
    output logic            ascii_valid
);
    import kbd_pkg::*;

    ascii_t lookup;

    // Set-2 make codes, unknown keys give zero
    always_comb begin
        case (scan_code)
            8'h1C: lookup = 8'h61;
            8'h32: lookup = 8'h62;
            8'h21: lookup = 8'h63;
            8'h23: lookup = 8'h64;
            8'h24: lookup = 8'h65;
            8'h2B: lookup = 8'h66;
            8'h34: lookup = 8'h67;
            8'h33: lookup = 8'h68;
            8'h43: lookup = 8'h69;
            8'h3B: lookup = 8'h6A;
            8'h42: lookup = 8'h6B;
            8'h4B: lookup = 8'h6C;
            8'h3A: lookup = 8'h6D;
            8'h31: lookup = 8'h6E;
            8'h44: lookup = 8'h6F;
            8'h4D: lookup = 8'h70;
            8'h15: lookup = 8'h71;
            8'h2D: lookup = 8'h72;
            8'h1B: lookup = 8'h73;
            8'h2C: lookup = 8'h74;
            8'h3C: lookup = 8'h75;
            8'h2A: lookup = 8'h76;
            8'h1D: lookup = 8'h77;
            8'h22: lookup = 8'h78;
            8'h35: lookup = 8'h79;
            8'h1A: lookup = 8'h7A;
            8'h45: lookup = 8'h30;
            8'h16: lookup = 8'h31;
            8'h1E: lookup = 8'h32;
            8'h26: lookup = 8'h33;
            8'h25: lookup = 8'h34;
            8'h2E: lookup = 8'h35;
            8'h36: lookup = 8'h36;
            8'h3D: lookup = 8'h37;
            8'h3E: lookup = 8'h38;
            8'h46: lookup = 8'h39;
            8'h29: lookup = 8'h20;
            // Enter sends carriage return
            8'h5A: lookup = 8'h0D;
            default: lookup = 8'h00;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (key_make) begin
            ascii <= lookup;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ascii_valid <= 1'b0;
        end else begin
            ascii_valid <= key_make;
        end
    end

endmodule

//--- logic/key_irq_ctrl.sv
`timescale 1ns/1ps

module key_irq_ctrl (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  kbd_pkg::ascii_t       ascii,
    input  logic                  ascii_valid,
    input  logic                  interrupt_ack,
    output kbd_pkg::ascii_t       key_value,
    output bus_map_pkg::irq_vec_t interrupt_vector
);
    import bus_map_pkg::*;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_value        <= '0;
            interrupt_vector <= '0;
        end else begin
            // Unknown keys arrive as zero and are dropped
            if (ascii_valid && ascii != '0) begin
                key_value        <= ascii;
                interrupt_vector <= KEY_IRQ_VECTOR;
            end
            // Ack comes last so it wins over a new press
            if (interrupt_ack && interrupt_vector != '0) begin
                interrupt_vector <= '0;
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        interrupt_vector == '0 || interrupt_vector == KEY_IRQ_VECTOR);

endmodule

//--- logic/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic                                    CLOCK_50,
    input  logic [bus_map_pkg::MEM_INDEX_BITS-1:0]  word_index,
    input  bus_map_pkg::mem_word_t                  write_data,
    input  logic                                    write_enable,
    output bus_map_pkg::mem_word_t                  read_data
);
    import bus_map_pkg::*;

    // First word past the ROM region
    localparam int ROM_END_WORD = int'((ROM_BASE + ROM_SIZE) >> 2);

    mem_word_t mem [MEM_WORDS];

    initial begin
        $readmemh("rom.hex", mem);
    end

    // Read returns old data when a write hits the same word
    always @(posedge CLOCK_50) begin
        read_data <= mem[word_index];
        if (write_enable && int'(word_index) >= ROM_END_WORD) begin
            mem[word_index] <= write_data;
        end
    end

endmodule

//--- logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                                    CLOCK_50,
    input  logic                                    KEY0,
    input  bus_map_pkg::bus_addr_t                  bus_address,
    input  bus_map_pkg::bus_data_t                  bus_write_data,
    input  logic                                    bus_write_enable,
    input  logic                                    bus_read_enable,
    input  bus_map_pkg::mem_word_t                  mem_read_data,
    input  kbd_pkg::ascii_t                         key_value,
    output logic [bus_map_pkg::MEM_INDEX_BITS-1:0]  mem_index,
    output bus_map_pkg::mem_word_t                  mem_write_data,
    output logic                                    mem_write_enable,
    output bus_map_pkg::bus_data_t                  bus_read_data,
    output kbd_pkg::ascii_t                         uart_tx_data,
    output logic                                    uart_tx_valid
);
    import bus_map_pkg::*;

    logic rom_sel;
    logic ram_sel;
    logic art_sel;
    logic key_sel;
    logic rd_mem;
    logic rd_key;
    logic art_write;
    logic art_write_d;

    assign rom_sel = (bus_address >= ROM_BASE) && (bus_address < ROM_BASE + ROM_SIZE);
    assign ram_sel = (bus_address >= RAM_BASE) && (bus_address < RAM_BASE + RAM_SIZE);
    assign art_sel = (bus_address == ART_BASE);
    assign key_sel = (bus_address == KEY_BASE);

    // Byte address to word index, both regions share one array
    assign mem_index        = bus_address[MEM_INDEX_BITS+1:2];
    assign mem_write_data   = bus_write_data[MEM_WORD_BITS-1:0];
    assign mem_write_enable = bus_write_enable && ram_sel;

    // Select lines up with the one-cycle memory read
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_mem <= 1'b0;
            rd_key <= 1'b0;
        end else begin
            rd_mem <= bus_read_enable && (rom_sel || ram_sel);
            rd_key <= bus_read_enable && key_sel;
        end
    end

    always_comb begin
        if (rd_mem) begin
            bus_read_data = bus_data_t'(mem_read_data);
        end else if (rd_key) begin
            bus_read_data = bus_data_t'(key_value);
        end else begin
            bus_read_data = '0;
        end
    end

    // Console strobe on the rising edge of a write
    assign art_write = bus_write_enable && art_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            art_write_d   <= 1'b0;
            uart_tx_valid <= 1'b0;
        end else begin
            art_write_d   <= art_write;
            uart_tx_valid <= art_write && !art_write_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (art_write && !art_write_d) begin
            uart_tx_data <= bus_write_data[7:0];
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) uart_tx_valid |=> !uart_tx_valid);

endmodule

//--- logic/board_bus.sv
`timescale 1ns/1ps

module board_bus (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  bus_map_pkg::bus_addr_t bus_address,
    input  bus_map_pkg::bus_data_t bus_write_data,
    input  logic                  bus_write_enable,
    input  logic                  bus_read_enable,
    output bus_map_pkg::bus_data_t bus_read_data,
    input  logic                  ps2_clk,
    input  logic                  ps2_dat,
    input  logic                  interrupt_ack,
    output bus_map_pkg::irq_vec_t interrupt_vector,
    output kbd_pkg::ascii_t       uart_tx_data,
    output logic                  uart_tx_valid
);
    import bus_map_pkg::*;
    import kbd_pkg::*;

    // Keyboard path
    scan_t                     scan_code;
    logic                      key_make;
    ascii_t                    ascii;
    logic                      ascii_valid;
    ascii_t                    key_value;

    // Memory port
    logic [MEM_INDEX_BITS-1:0] mem_index;
    mem_word_t                 mem_write_data;
    logic                      mem_write_enable;
    mem_word_t                 mem_read_data;

    ps2_frame_fsm ps2_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .scan_code (scan_code),
        .key_make  (key_make),
        .key_break ()
    );

    scan_ascii_table table_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .scan_code   (scan_code),
        .key_make    (key_make),
        .ascii       (ascii),
        .ascii_valid (ascii_valid)
    );

    key_irq_ctrl irq_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .ascii            (ascii),
        .ascii_valid      (ascii_valid),
        .interrupt_ack    (interrupt_ack),
        .key_value        (key_value),
        .interrupt_vector (interrupt_vector)
    );

    word_ram ram_i (
        .CLOCK_50     (CLOCK_50),
        .word_index   (mem_index),
        .write_data   (mem_write_data),
        .write_enable (mem_write_enable),
        .read_data    (mem_read_data)
    );

    bus_decoder decoder_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .mem_read_data    (mem_read_data),
        .key_value        (key_value),
        .mem_index        (mem_index),
        .mem_write_data   (mem_write_data),
        .mem_write_enable (mem_write_enable),
        .bus_read_data    (bus_read_data),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_valid    (uart_tx_valid)
    );

endmodule

//--- verif/board_bus_tb.sv
`timescale 1ns/1ps

module board_bus_tb;
    import bus_map_pkg::*;
    import kbd_pkg::*;

    logic        CLOCK_50;
    logic        KEY0;
    bus_addr_t   bus_address;
    bus_data_t   bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    bus_data_t   bus_read_data;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        interrupt_ack;
    irq_vec_t    interrupt_vector;
    ascii_t      uart_tx_data;
    logic        uart_tx_valid;

    // Expectations set by the stimulus in the same cycle as the enables
    bus_data_t   read_expect = '0;
    logic        tx_expect = 1'b0;
    ascii_t      tx_byte = '0;
    logic        irq_quiet = 1'b1;
    bus_data_t   read_expect_q = '0;
    logic        read_check_q = 1'b0;
    logic        tx_expect_q = 1'b0;
    ascii_t      tx_byte_q = '0;
    bus_data_t   read_want;

    string       test_name = "reset";
    int          value_errors = 0;
    int          timeout_errors = 0;
    logic [31:0] lcg_state;
    mem_word_t   ram_model [MEM_WORDS];
    bit          ram_seen [MEM_WORDS];
    int          ram_order [$];

    board_bus dut_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .ps2_clk          (ps2_clk),
        .ps2_dat          (ps2_dat),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_valid    (uart_tx_valid)
    );

    always #50 CLOCK_50 = ~CLOCK_50;

    // Responses are due one cycle after the request
    always @(posedge CLOCK_50) begin
        read_check_q  <= bus_read_enable;
        read_expect_q <= read_expect;
        tx_expect_q   <= tx_expect;
        tx_byte_q     <= tx_byte;
    end

    assign read_want = read_check_q ? read_expect_q : '0;

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bus_read_data == read_want)
    else begin
        value_errors++;
        $display("[FAIL] %s read: expected %h, actual %h", test_name,
            $sampled(read_want), $sampled(bus_read_data));
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) uart_tx_valid == tx_expect_q)
    else begin
        value_errors++;
        $display("[FAIL] %s console strobe: expected %b, actual %b", test_name,
            $sampled(tx_expect_q), $sampled(uart_tx_valid));
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_tx_valid |-> uart_tx_data == tx_byte_q)
    else begin
        value_errors++;
        $display("[FAIL] %s console byte: expected %h, actual %h", test_name,
            $sampled(tx_byte_q), $sampled(uart_tx_data));
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) irq_quiet |-> interrupt_vector == '0)
    else begin
        value_errors++;
        $display("[FAIL] %s quiet vector: expected %h, actual %h", test_name,
            irq_vec_t'(0), $sampled(interrupt_vector));
    end

    // Vector holds until acked, then drops on the next edge
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        interrupt_vector != '0 && !interrupt_ack |=> interrupt_vector == KEY_IRQ_VECTOR)
    else begin
        value_errors++;
        $display("[FAIL] %s vector hold: expected %h, actual %h", test_name,
            KEY_IRQ_VECTOR, $sampled(interrupt_vector));
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        interrupt_vector != '0 && interrupt_ack |=> interrupt_vector == '0)
    else begin
        value_errors++;
        $display("[FAIL] %s vector clear: expected %h, actual %h", test_name,
            irq_vec_t'(0), $sampled(interrupt_vector));
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bus tasks start and end just after a falling edge
    task automatic bus_read(input bus_addr_t addr, input bus_data_t expect_data);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        read_expect     = expect_data;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        read_expect     = '0;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input int hold);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        tx_expect        = (addr == ART_BASE);
        tx_byte          = data[7:0];
        for (int i = 0; i < hold; i++) begin
            @(negedge CLOCK_50);
            tx_expect = 1'b0;
        end
        bus_write_enable = 1'b0;
    endtask

    // Keyboard side, data changes mid-way through the high phase
    task automatic ps2_send(input scan_t code, input logic bad_parity, input int bit_count);
        logic [FRAME_BITS-1:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < bit_count; i++) begin
            ps2_dat = frame[i];
            repeat (10) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (20) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
            repeat (10) @(negedge CLOCK_50);
        end
        ps2_dat = 1'b1;
        repeat (20) @(negedge CLOCK_50);
    endtask

    task automatic wait_vector(input irq_vec_t value, input int limit);
        int count;
        count = 0;
        while (interrupt_vector != value && count < limit) begin
            @(negedge CLOCK_50);
            count++;
        end
        if (interrupt_vector != value) begin
            timeout_errors++;
            $display("%s: interrupt vector did not reach %0d within %0d cycles",
                test_name, value, limit);
        end
    endtask

    task automatic ack_interrupt();
        interrupt_ack = 1'b1;
        @(negedge CLOCK_50);
        interrupt_ack = 1'b0;
    endtask

    initial begin
        int          idx;
        int          pick;
        int          tmp;
        logic [31:0] hi;
        CLOCK_50         = 1'b0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        ps2_clk          = 1'b1;
        ps2_dat          = 1'b1;
        interrupt_ack    = 1'b0;
        lcg_state        = 32'hd3eb_f120;
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        test_name = "rom";
        for (int i = 0; i < 16; i++) begin
            bus_read(bus_addr_t'(i * 4), bus_data_t'(32'hC0DE_0000 + i));
        end
        bus_write(64'h0C, 64'hFFFF_FFFF_1234_5678, 1);
        bus_read(64'h0C, 64'hC0DE_0003);

        test_name = "ram";
        for (int n = 0; n < 12; n++) begin
            lcg_state = lcg_next(lcg_state);
            idx       = int'(RAM_BASE >> 2) + int'(lcg_state[21:16]);
            lcg_state = lcg_next(lcg_state);
            hi        = lcg_state;
            lcg_state = lcg_next(lcg_state);
            ram_model[idx] = lcg_state;
            if (!ram_seen[idx]) begin
                ram_seen[idx] = 1'b1;
                ram_order.push_back(idx);
            end
            bus_write(bus_addr_t'(idx * 4), {hi, lcg_state}, 1);
        end
        for (int i = ram_order.size() - 1; i > 0; i--) begin
            lcg_state    = lcg_next(lcg_state);
            pick         = int'(lcg_state[23:16]) % (i + 1);
            tmp          = ram_order[i];
            ram_order[i] = ram_order[pick];
            ram_order[pick] = tmp;
        end
        foreach (ram_order[k]) begin
            bus_read(bus_addr_t'(ram_order[k] * 4), bus_data_t'(ram_model[ram_order[k]]));
        end
        test_name = "unmapped";
        bus_read(64'h200, '0);
        bus_read(ART_BASE, '0);
        bus_read(64'h1010, '0);
        bus_read(64'h8000_0000_0000_0004, '0);

        test_name = "console";
        bus_write(ART_BASE, 64'h0123_4567_89AB_CD5A, 1);
        repeat (3) @(negedge CLOCK_50);
        bus_write(ART_BASE, 64'h0000_0000_0000_0042, 3);
        repeat (3) @(negedge CLOCK_50);

        test_name = "key press";
        irq_quiet = 1'b0;
        ps2_send(8'h1C, 1'b0, FRAME_BITS);
        wait_vector(KEY_IRQ_VECTOR, 100);
        bus_read(KEY_BASE, 64'h61);
        repeat (10) @(negedge CLOCK_50);
        ack_interrupt();
        wait_vector('0, 10);
        irq_quiet = 1'b1;

        test_name = "ignored frames";
        ps2_send(BREAK_CODE, 1'b0, FRAME_BITS);
        ps2_send(8'h1C, 1'b0, FRAME_BITS);
        // Another key, so an accepted frame would change the key register
        ps2_send(8'h32, 1'b1, FRAME_BITS);
        ps2_send(8'h32, 1'b0, 4);
        // Long enough for the partial frame to be abandoned
        repeat (IDLE_TIMEOUT + 200) @(negedge CLOCK_50);
        bus_read(KEY_BASE, 64'h61);
        irq_quiet = 1'b0;
        ps2_send(8'h2E, 1'b0, FRAME_BITS);
        wait_vector(KEY_IRQ_VECTOR, 100);
        bus_read(KEY_BASE, 64'h35);
        ack_interrupt();
        wait_vector('0, 10);
        irq_quiet = 1'b1;

        repeat (5) @(negedge CLOCK_50);
        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- board_bus.f
logic/bus_map_pkg.sv
logic/kbd_pkg.sv
logic/ps2_frame_timer.sv
logic/ps2_frame_fsm.sv
logic/scan_ascii_table.sv
logic/key_irq_ctrl.sv
logic/word_ram.sv
logic/bus_decoder.sv
logic/board_bus.sv
verif/board_bus_tb.sv

//--- Makefile
SOURCES := $(shell cat board_bus.f)

.PHONY: run clean

run: obj_dir/Vboard_bus_tb
	@out="$$(./obj_dir/Vboard_bus_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

obj_dir/Vboard_bus_tb: board_bus.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module board_bus_tb \
		-f board_bus.f -o Vboard_bus_tb

clean:
	rm -rf obj_dir

//--- rom.hex
// ROM words 0 to 15, one 32-bit hex word per line
C0DE0000
C0DE0001
C0DE0002
C0DE0003
C0DE0004
C0DE0005
C0DE0006
C0DE0007
C0DE0008
C0DE0009
C0DE000A
C0DE000B
C0DE000C
C0DE000D
C0DE000E
C0DE000F
